//--- rtl/mipsPkg.sv
// MIPS32 core definitions
package mipsPkg;

   // Datapath and register index widths
   localparam int dataW    = 32;
   localparam int regAddrW = 5;

   // Memory sizes in words
   localparam int imemDepth = 64;
   localparam int dmemDepth = 64;

   // Primary opcodes, instr[31:26]
   localparam logic [5:0] opRType = 6'h00;
   localparam logic [5:0] opAddi  = 6'h08;
   localparam logic [5:0] opLw    = 6'h23;
   localparam logic [5:0] opSw    = 6'h2b;
   localparam logic [5:0] opBeq   = 6'h04;

   // R-type function codes, instr[5:0]
   localparam logic [5:0] fnAdd = 6'h20;
   localparam logic [5:0] fnSub = 6'h22;
   localparam logic [5:0] fnAnd = 6'h24;
   localparam logic [5:0] fnOr  = 6'h25;
   localparam logic [5:0] fnSlt = 6'h2a;

   // ALU operation class from decode
   typedef enum logic [1:0] {
      aluAdd   = 2'b00,
      aluSub   = 2'b01,
      aluFunct = 2'b10
   } aluOpT;

   // ALU operation, classic encoding
   typedef enum logic [3:0] {
      ctrlAnd = 4'b0000,
      ctrlOr  = 4'b0001,
      ctrlAdd = 4'b0010,
      ctrlSub = 4'b0110,
      ctrlSlt = 4'b0111
   } aluCtrlT;

   // Bubble word
   localparam logic [dataW-1:0] nopInstr = '0;

endpackage

//--- rtl/mipsFetch.sv
// Instruction fetch stage
`timescale 1ns/1ps

module mipsFetch (
   input  logic                                Clk,
   input  logic                                arstN,
   input  logic                                run,
   input  logic                                imemWe,
   input  logic [$clog2(mipsPkg::imemDepth)-1:0] imemAddr,
   input  logic [mipsPkg::dataW-1:0]           imemData,
   input  logic                                branchTaken,
   input  logic [mipsPkg::dataW-1:0]           branchTarget,
   output logic [mipsPkg::dataW-1:0]           instrId,
   output logic [mipsPkg::dataW-1:0]           pcPlus4Id
);
   import mipsPkg::*;

   logic [dataW-1:0] pc;
   logic [dataW-1:0] pcPlus4;
   logic [dataW-1:0] instrIf;
   logic [dataW-1:0] imem [imemDepth];

   // Load port, one word per cycle
   always_ff @(posedge Clk) begin
      if (imemWe) begin
         imem[imemAddr] <= imemData;
      end
   end

   // Word index from the byte PC
   assign instrIf = imem[pc[$clog2(imemDepth)+1:2]];
   assign pcPlus4 = pc + 32'd4;

   // Branch wins even when stopped
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
      end else if (branchTaken) begin
         pc <= branchTarget;
      end else if (run) begin
         pc <= pcPlus4;
      end
   end

   // IF/ID, bubble when stopped or flushed
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         instrId <= nopInstr;
      end else if (branchTaken || !run) begin
         instrId <= nopInstr;
      end else begin
         instrId <= instrIf;
      end
   end

   // Return address for the branch adder
   always_ff @(posedge Clk) begin
      pcPlus4Id <= pcPlus4;
   end

endmodule

//--- rtl/mipsDecode.sv
// Instruction decode stage
`timescale 1ns/1ps

module mipsDecode (
   input  logic                         Clk,
   input  logic                         arstN,
   input  logic [mipsPkg::dataW-1:0]    instrId,
   input  logic [mipsPkg::dataW-1:0]    pcPlus4Id,
   input  logic                         wbValid,
   input  logic [mipsPkg::regAddrW-1:0] wbReg,
   input  logic [mipsPkg::dataW-1:0]    wbData,
   output logic                         branchTaken,
   output logic [mipsPkg::dataW-1:0]    branchTarget,
   output logic                         regWriteEx,
   output logic                         memReadEx,
   output logic                         memWriteEx,
   output logic                         memToRegEx,
   output logic                         aluSrcEx,
   output logic                         regDstEx,
   output mipsPkg::aluOpT               aluOpEx,
   output logic [mipsPkg::dataW-1:0]    readData1Ex,
   output logic [mipsPkg::dataW-1:0]    readData2Ex,
   output logic [mipsPkg::dataW-1:0]    immEx,
   output logic [mipsPkg::dataW-1:0]    instrEx,
   output logic [mipsPkg::regAddrW-1:0] rsEx,
   output logic [mipsPkg::regAddrW-1:0] rtEx,
   output logic [mipsPkg::regAddrW-1:0] rdEx
);
   import mipsPkg::*;

   logic [dataW-1:0]    regFile [2**regAddrW];
   logic [regAddrW-1:0] rsId;
   logic [regAddrW-1:0] rtId;
   logic [regAddrW-1:0] rdId;
   logic [dataW-1:0]    readData1;
   logic [dataW-1:0]    readData2;
   logic [dataW-1:0]    immId;
   logic                regWrite;
   logic                memRead;
   logic                memWrite;
   logic                memToReg;
   logic                aluSrc;
   logic                regDst;
   logic                isBeq;
   aluOpT               aluOp;

   // Register read, r0 hardwired, writeback passes straight through
   function automatic logic [dataW-1:0] readReg(input logic [regAddrW-1:0] addr);
      if (addr == '0) begin
         return '0;
      end else if (wbValid && (wbReg == addr)) begin
         return wbData;
      end
      return regFile[addr];
   endfunction

   assign rsId = instrId[25:21];
   assign rtId = instrId[20:16];
   assign rdId = instrId[15:11];

   // Write port from writeback, r0 already filtered there
   always_ff @(posedge Clk) begin
      if (wbValid) begin
         regFile[wbReg] <= wbData;
      end
   end

   always_comb begin
      readData1 = readReg(rsId);
      readData2 = readReg(rtId);
   end

   // Main control, all-zero word is a bubble
   always_comb begin
      regWrite = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      memToReg = 1'b0;
      aluSrc   = 1'b0;
      regDst   = 1'b0;
      isBeq    = 1'b0;
      aluOp    = aluAdd;
      if (instrId != nopInstr) begin
         case (instrId[31:26])
            opRType: begin
               regWrite = 1'b1;
               regDst   = 1'b1;
               aluOp    = aluFunct;
            end
            opAddi: begin
               regWrite = 1'b1;
               aluSrc   = 1'b1;
            end
            opLw: begin
               regWrite = 1'b1;
               memRead  = 1'b1;
               memToReg = 1'b1;
               aluSrc   = 1'b1;
            end
            opSw: begin
               memWrite = 1'b1;
               aluSrc   = 1'b1;
            end
            opBeq: begin
               isBeq = 1'b1;
               aluOp = aluSub;
            end
            default: ;
         endcase
      end
   end

   assign immId = {{(dataW-16){instrId[15]}}, instrId[15:0]};

   // Branch resolved here, word offset from PC plus four
   assign branchTarget = pcPlus4Id + {immId[dataW-3:0], 2'b00};
   assign branchTaken  = isBeq && (readData1 == readData2);

   // ID/EX control
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         regWriteEx <= 1'b0;
         memReadEx  <= 1'b0;
         memWriteEx <= 1'b0;
         memToRegEx <= 1'b0;
         aluSrcEx   <= 1'b0;
         regDstEx   <= 1'b0;
         aluOpEx    <= aluAdd;
      end else begin
         regWriteEx <= regWrite;
         memReadEx  <= memRead;
         memWriteEx <= memWrite;
         memToRegEx <= memToReg;
         aluSrcEx   <= aluSrc;
         regDstEx   <= regDst;
         aluOpEx    <= aluOp;
      end
   end

   // ID/EX operands and fields
   always_ff @(posedge Clk) begin
      readData1Ex <= readData1;
      readData2Ex <= readData2;
      immEx       <= immId;
      instrEx     <= instrId;
      rsEx        <= rsId;
      rtEx        <= rtId;
      rdEx        <= rdId;
   end

endmodule

//--- rtl/mipsExecute.sv
// Execute stage
`timescale 1ns/1ps

module mipsExecute (
   input  logic                         Clk,
   input  logic                         arstN,
   input  logic                         regWriteEx,
   input  logic                         memReadEx,
   input  logic                         memWriteEx,
   input  logic                         memToRegEx,
   input  logic                         aluSrcEx,
   input  logic                         regDstEx,
   input  mipsPkg::aluOpT               aluOpEx,
   input  logic [mipsPkg::dataW-1:0]    readData1Ex,
   input  logic [mipsPkg::dataW-1:0]    readData2Ex,
   input  logic [mipsPkg::dataW-1:0]    immEx,
   input  logic [mipsPkg::dataW-1:0]    instrEx,
   input  logic [mipsPkg::regAddrW-1:0] rsEx,
   input  logic [mipsPkg::regAddrW-1:0] rtEx,
   input  logic [mipsPkg::regAddrW-1:0] rdEx,
   input  logic                         wbValid,
   input  logic [mipsPkg::regAddrW-1:0] wbReg,
   input  logic [mipsPkg::dataW-1:0]    wbData,
   output logic                         regWriteMem,
   output logic                         memReadMem,
   output logic                         memWriteMem,
   output logic                         memToRegMem,
   output logic [mipsPkg::dataW-1:0]    aluResultMem,
   output logic [mipsPkg::dataW-1:0]    storeDataMem,
   output logic [mipsPkg::regAddrW-1:0] writeRegMem
);
   import mipsPkg::*;

   logic [dataW-1:0]    opA;
   logic [dataW-1:0]    fwdB;
   logic [dataW-1:0]    opB;
   logic [dataW-1:0]    aluResult;
   logic [regAddrW-1:0] writeReg;
   aluCtrlT             aluCtrl;

   // Newest producer first, memory stage then writeback
   function automatic logic [dataW-1:0] fwd(input logic [regAddrW-1:0] src,
                                            input logic [dataW-1:0] regVal);
      if (regWriteMem && (writeRegMem != '0) && (writeRegMem == src)) begin
         return aluResultMem;
      end else if (wbValid && (wbReg == src)) begin
         return wbData;
      end
      return regVal;
   endfunction

   always_comb begin
      opA  = fwd(rsEx, readData1Ex);
      fwdB = fwd(rtEx, readData2Ex);
   end

   // Immediate for addi, lw and sw
   assign opB = aluSrcEx ? immEx : fwdB;

   // ALU control from class and function code
   always_comb begin
      aluCtrl = ctrlAdd;
      case (aluOpEx)
         aluSub: aluCtrl = ctrlSub;
         aluFunct: begin
            case (instrEx[5:0])
               fnSub:   aluCtrl = ctrlSub;
               fnAnd:   aluCtrl = ctrlAnd;
               fnOr:    aluCtrl = ctrlOr;
               fnSlt:   aluCtrl = ctrlSlt;
               fnAdd:   aluCtrl = ctrlAdd;
               default: aluCtrl = ctrlAdd;
            endcase
         end
         default: aluCtrl = ctrlAdd;
      endcase
   end

   always_comb begin
      case (aluCtrl)
         ctrlAnd: aluResult = opA & opB;
         ctrlOr:  aluResult = opA | opB;
         ctrlSub: aluResult = opA - opB;
         // Signed compare
         ctrlSlt: aluResult = {{(dataW-1){1'b0}}, $signed(opA) < $signed(opB)};
         default: aluResult = opA + opB;
      endcase
   end

   // rd for R-type, rt otherwise
   assign writeReg = regDstEx ? rdEx : rtEx;

   // EX/MEM control
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         regWriteMem <= 1'b0;
         memReadMem  <= 1'b0;
         memWriteMem <= 1'b0;
         memToRegMem <= 1'b0;
      end else begin
         regWriteMem <= regWriteEx;
         memReadMem  <= memReadEx;
         memWriteMem <= memWriteEx;
         memToRegMem <= memToRegEx;
      end
   end

   // EX/MEM payload, store data is the forwarded rt
   always_ff @(posedge Clk) begin
      aluResultMem <= aluResult;
      storeDataMem <= fwdB;
      writeRegMem  <= writeReg;
   end

endmodule

//--- rtl/mipsMemory.sv
// Memory and writeback stage
`timescale 1ns/1ps

module mipsMemory (
   input  logic                         Clk,
   input  logic                         arstN,
   input  logic                         regWriteMem,
   input  logic                         memReadMem,
   input  logic                         memWriteMem,
   input  logic                         memToRegMem,
   input  logic [mipsPkg::dataW-1:0]    aluResultMem,
   input  logic [mipsPkg::dataW-1:0]    storeDataMem,
   input  logic [mipsPkg::regAddrW-1:0] writeRegMem,
   output logic                         wbValid,
   output logic [mipsPkg::regAddrW-1:0] wbReg,
   output logic [mipsPkg::dataW-1:0]    wbData
);
   import mipsPkg::*;

   logic [dataW-1:0]                dmem [dmemDepth];
   logic [$clog2(dmemDepth)-1:0]    dmemIdx;
   logic [dataW-1:0]                loadData;
   logic                            regWriteWb;

   // Byte address to word index
   assign dmemIdx = aluResultMem[$clog2(dmemDepth)+1:2];

   // Store on the edge
   always_ff @(posedge Clk) begin
      if (memWriteMem) begin
         dmem[dmemIdx] <= storeDataMem;
      end
   end

   // Combinational load
   assign loadData = memReadMem ? dmem[dmemIdx] : '0;

   // MEM/WB write flag
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         regWriteWb <= 1'b0;
      end else begin
         regWriteWb <= regWriteMem;
      end
   end

   // Writeback select folded into MEM/WB
   always_ff @(posedge Clk) begin
      wbReg  <= writeRegMem;
      wbData <= memToRegMem ? loadData : aluResultMem;
   end

   // Writes to r0 are dropped
   assign wbValid = regWriteWb && (wbReg != '0);

endmodule

//--- rtl/mips32.sv
// Five-stage MIPS32 core
`timescale 1ns/1ps

module mips32 (
   input  logic                                  Clk,
   input  logic                                  arstN,
   input  logic                                  run,
   input  logic                                  imemWe,
   input  logic [$clog2(mipsPkg::imemDepth)-1:0] imemAddr,
   input  logic [mipsPkg::dataW-1:0]             imemData,
   output logic                                  wbValid,
   output logic [mipsPkg::regAddrW-1:0]          wbReg,
   output logic [mipsPkg::dataW-1:0]             wbData
);
   import mipsPkg::*;

   // IF/ID and branch feedback
   logic [dataW-1:0]    instrId;
   logic [dataW-1:0]    pcPlus4Id;
   logic                branchTaken;
   logic [dataW-1:0]    branchTarget;

   // ID/EX
   logic                regWriteEx;
   logic                memReadEx;
   logic                memWriteEx;
   logic                memToRegEx;
   logic                aluSrcEx;
   logic                regDstEx;
   aluOpT               aluOpEx;
   logic [dataW-1:0]    readData1Ex;
   logic [dataW-1:0]    readData2Ex;
   logic [dataW-1:0]    immEx;
   logic [dataW-1:0]    instrEx;
   logic [regAddrW-1:0] rsEx;
   logic [regAddrW-1:0] rtEx;
   logic [regAddrW-1:0] rdEx;

   // EX/MEM
   logic                regWriteMem;
   logic                memReadMem;
   logic                memWriteMem;
   logic                memToRegMem;
   logic [dataW-1:0]    aluResultMem;
   logic [dataW-1:0]    storeDataMem;
   logic [regAddrW-1:0] writeRegMem;

   mipsFetch fetch (
      .Clk          (Clk),
      .arstN        (arstN),
      .run          (run),
      .imemWe       (imemWe),
      .imemAddr     (imemAddr),
      .imemData     (imemData),
      .branchTaken  (branchTaken),
      .branchTarget (branchTarget),
      .instrId      (instrId),
      .pcPlus4Id    (pcPlus4Id)
   );

   // Writeback port doubles as register file write port
   mipsDecode decode (
      .Clk          (Clk),
      .arstN        (arstN),
      .instrId      (instrId),
      .pcPlus4Id    (pcPlus4Id),
      .wbValid      (wbValid),
      .wbReg        (wbReg),
      .wbData       (wbData),
      .branchTaken  (branchTaken),
      .branchTarget (branchTarget),
      .regWriteEx   (regWriteEx),
      .memReadEx    (memReadEx),
      .memWriteEx   (memWriteEx),
      .memToRegEx   (memToRegEx),
      .aluSrcEx     (aluSrcEx),
      .regDstEx     (regDstEx),
      .aluOpEx      (aluOpEx),
      .readData1Ex  (readData1Ex),
      .readData2Ex  (readData2Ex),
      .immEx        (immEx),
      .instrEx      (instrEx),
      .rsEx         (rsEx),
      .rtEx         (rtEx),
      .rdEx         (rdEx)
   );

   mipsExecute execute (
      .Clk          (Clk),
      .arstN        (arstN),
      .regWriteEx   (regWriteEx),
      .memReadEx    (memReadEx),
      .memWriteEx   (memWriteEx),
      .memToRegEx   (memToRegEx),
      .aluSrcEx     (aluSrcEx),
      .regDstEx     (regDstEx),
      .aluOpEx      (aluOpEx),
      .readData1Ex  (readData1Ex),
      .readData2Ex  (readData2Ex),
      .immEx        (immEx),
      .instrEx      (instrEx),
      .rsEx         (rsEx),
      .rtEx         (rtEx),
      .rdEx         (rdEx),
      .wbValid      (wbValid),
      .wbReg        (wbReg),
      .wbData       (wbData),
      .regWriteMem  (regWriteMem),
      .memReadMem   (memReadMem),
      .memWriteMem  (memWriteMem),
      .memToRegMem  (memToRegMem),
      .aluResultMem (aluResultMem),
      .storeDataMem (storeDataMem),
      .writeRegMem  (writeRegMem)
   );

   mipsMemory memory (
      .Clk          (Clk),
      .arstN        (arstN),
      .regWriteMem  (regWriteMem),
      .memReadMem   (memReadMem),
      .memWriteMem  (memWriteMem),
      .memToRegMem  (memToRegMem),
      .aluResultMem (aluResultMem),
      .storeDataMem (storeDataMem),
      .writeRegMem  (writeRegMem),
      .wbValid      (wbValid),
      .wbReg        (wbReg),
      .wbData       (wbData)
   );

endmodule

//--- verif/mips32_props.sv
// Writeback port assertions
`timescale 1ns/1ps

module mips32Props (
   input logic                         Clk,
   input logic                         arstN,
   input logic                         wbValid,
   input logic [mipsPkg::regAddrW-1:0] wbReg
);

   // r0 never retires
   property noZeroDest;
      @(posedge Clk) disable iff (!arstN) wbValid |-> (wbReg != '0);
   endproperty

   // Quiet while in reset
   property lowInReset;
      @(posedge Clk) !arstN |-> !wbValid;
   endproperty

   property knownValid;
      @(posedge Clk) disable iff (!arstN) !$isunknown(wbValid);
   endproperty

   assert property (noZeroDest) else $error("wbValid high with wbReg zero");
   assert property (lowInReset) else $error("wbValid high during reset");
   assert property (knownValid) else $error("wbValid unknown after reset");

endmodule

bind mips32 mips32Props props (
   .Clk     (Clk),
   .arstN   (arstN),
   .wbValid (wbValid),
   .wbReg   (wbReg)
);

//--- verif/mips32Tb.sv
// MIPS32 core testbench
`timescale 1ns/1ps

module mips32Tb;
   import mipsPkg::*;

   logic                         Clk;
   logic                         arstN;
   logic                         run;
   logic                         imemWe;
   logic [$clog2(imemDepth)-1:0] imemAddr;
   logic [dataW-1:0]             imemData;
   logic                         wbValid;
   logic [regAddrW-1:0]          wbReg;
   logic [dataW-1:0]             wbData;

   // Program words and expected retirements, in program order
   logic [dataW-1:0] prog [$];
   logic [dataW-1:0] expReg [$];
   logic [dataW-1:0] expData [$];
   // Architectural register view
   logic [dataW-1:0] model [32];
   integer           seed;

   mips32 dut (
      .Clk      (Clk),
      .arstN    (arstN),
      .run      (run),
      .imemWe   (imemWe),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .wbValid  (wbValid),
      .wbReg    (wbReg),
      .wbData   (wbData)
   );

   always #4 Clk = ~Clk;

   function automatic logic [dataW-1:0] encodeR(input logic [5:0] fn, input int rd,
                                                input int rs, input int rt);
      return {opRType, rs[4:0], rt[4:0], rd[4:0], 5'b00000, fn};
   endfunction

   function automatic logic [dataW-1:0] encodeI(input logic [5:0] op, input int rt,
                                                input int rs, input logic [15:0] imm);
      return {op, rs[4:0], rt[4:0], imm};
   endfunction

   function automatic logic [dataW-1:0] signExtend(input logic [15:0] imm);
      return {{16{imm[15]}}, imm};
   endfunction

   function automatic logic [dataW-1:0] signedLess(input logic [dataW-1:0] a,
                                                   input logic [dataW-1:0] b);
      return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
   endfunction

   task automatic failRun(input string reason);
      $display("%s", reason);
      $display("Test failures found");
      $fatal(1, "stopping at first error");
   endtask

   task automatic checkValue(input string name, input logic [dataW-1:0] actual,
                             input logic [dataW-1:0] expected);
      if (actual !== expected) begin
         failRun($sformatf("MISMATCH %s: got 0x%08h expected 0x%08h",
                           name, actual, expected));
      end
   endtask

   // Records a retiring write, r0 writes are silent
   task automatic expectWrite(input int rd, input logic [dataW-1:0] value);
      if (rd != 0) begin
         model[rd] = value;
         expReg.push_back(rd);
         expData.push_back(value);
      end
   endtask

   task automatic buildProgram();
      logic [31:0]      rnd;
      logic [15:0]      immA;
      logic [15:0]      immB;
      logic [15:0]      immC;
      logic [dataW-1:0] stored;
      rnd  = $random(seed);
      immA = {1'b0, rnd[14:0]};
      rnd  = $random(seed);
      immB = {1'b1, rnd[14:0]};
      rnd  = $random(seed);
      immC = rnd[15:0];
      // Operands from positive and negative immediates
      prog.push_back(encodeI(opAddi, 1, 0, immA));
      expectWrite(1, model[0] + signExtend(immA));
      prog.push_back(encodeI(opAddi, 2, 0, immB));
      expectWrite(2, model[0] + signExtend(immB));
      // Dependent chain, sources one and two back
      prog.push_back(encodeR(fnAdd, 3, 1, 2));
      expectWrite(3, model[1] + model[2]);
      prog.push_back(encodeR(fnSub, 4, 3, 1));
      expectWrite(4, model[3] - model[1]);
      prog.push_back(encodeR(fnAnd, 5, 4, 3));
      expectWrite(5, model[4] & model[3]);
      prog.push_back(encodeR(fnOr, 6, 5, 4));
      expectWrite(6, model[5] | model[4]);
      prog.push_back(encodeR(fnSlt, 7, 2, 1));
      expectWrite(7, signedLess(model[2], model[1]));
      prog.push_back(encodeR(fnSlt, 8, 6, 7));
      expectWrite(8, signedLess(model[6], model[7]));
      // Write to r0, then read r0 right behind it
      prog.push_back(encodeI(opAddi, 0, 1, 16'h0005));
      expectWrite(0, model[1] + signExtend(16'h0005));
      prog.push_back(encodeR(fnAdd, 9, 0, 1));
      expectWrite(9, model[0] + model[1]);
      // Store with forwarded data, spacer, load back
      prog.push_back(encodeI(opSw, 9, 0, 16'h0008));
      stored = model[9];
      prog.push_back(encodeI(opAddi, 10, 2, immC));
      expectWrite(10, model[2] + signExtend(immC));
      prog.push_back(encodeI(opLw, 11, 0, 16'h0008));
      expectWrite(11, stored);
      prog.push_back(encodeI(opAddi, 12, 0, 16'h0001));
      expectWrite(12, model[0] + signExtend(16'h0001));
      prog.push_back(encodeR(fnAdd, 13, 11, 12));
      expectWrite(13, model[11] + model[12]);
      // r1 equals r9, so the addi behind it is skipped
      prog.push_back(encodeI(opBeq, 9, 1, 16'h0001));
      prog.push_back(encodeI(opAddi, 14, 0, 16'h07ff));
      // r1 is positive and r2 negative, falls through
      prog.push_back(encodeI(opBeq, 2, 1, 16'h0001));
      prog.push_back(encodeI(opAddi, 15, 0, 16'h0123));
      expectWrite(15, model[0] + signExtend(16'h0123));
      prog.push_back(encodeR(fnAdd, 16, 12, 0));
      expectWrite(16, model[12] + model[0]);
      // Branch to itself parks the core
      prog.push_back(encodeI(opBeq, 0, 0, 16'hffff));
   endtask

   // Samples one cycle at a time, 20 cycles at most
   task automatic waitWriteback(input int idx);
      int cycles;
      cycles = 0;
      do begin
         @(posedge Clk);
         #1;
         cycles++;
      end while (!wbValid && cycles < 20);
      if (!wbValid) begin
         failRun($sformatf("Timeout waiting for writeback number %0d", idx));
      end
   endtask

   initial begin
      Clk      = 1'b0;
      arstN    = 1'b0;
      run      = 1'b0;
      imemWe   = 1'b0;
      imemAddr = '0;
      imemData = '0;
      seed     = 30797;
      foreach (model[i]) begin
         model[i] = '0;
      end
      buildProgram();
      repeat (8) begin
         @(posedge Clk);
         #1;
         checkValue("wbValid", 32'(wbValid), 32'd0);
      end
      arstN = 1'b1;
      // Load with the core stopped
      for (int i = 0; i < prog.size(); i++) begin
         @(posedge Clk);
         #1;
         checkValue("wbValid", 32'(wbValid), 32'd0);
         imemWe   = 1'b1;
         imemAddr = i[$clog2(imemDepth)-1:0];
         imemData = prog[i];
      end
      @(posedge Clk);
      #1;
      imemWe = 1'b0;
      run    = 1'b1;
      for (int k = 0; k < expReg.size(); k++) begin
         waitWriteback(k);
         checkValue("wbReg", 32'(wbReg), expReg[k]);
         checkValue("wbData", wbData, expData[k]);
      end
      // Parked in the branch loop, nothing may retire
      repeat (40) begin
         @(posedge Clk);
         #1;
         if (wbValid) begin
            failRun($sformatf("Unexpected writeback to register %0d after program end",
                              wbReg));
         end
      end
      $display("All tests passed!");
      $finish;
   end

endmodule

//--- mips32.f
rtl/mipsPkg.sv
rtl/mipsFetch.sv
rtl/mipsDecode.sv
rtl/mipsExecute.sv
rtl/mipsMemory.sv
rtl/mips32.sv
verif/mips32_props.sv
verif/mips32Tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build mips32Tb with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module mips32Tb -Mdir obj_dir -f mips32.f
	./obj_dir/Vmips32Tb

clean:
	rm -rf obj_dir
